//--- design/fetch_fifo.sv
module fetch_fifo (
  input  logic                             clk,
  input  logic                             rst_n,

  // Drop all buffered words
  input  logic                             flush_i,

  // Write side
  input  logic                             push_i,
  input  logic [prefetch_pkg::ADDR_W-1:0]  push_data_i,
  output logic [prefetch_pkg::CNT_W-1:0]   cnt_o,

  // Read side towards the fetch stage
  output logic                             valid_o,
  input  logic                             ready_i,
  output logic [prefetch_pkg::ADDR_W-1:0]  rdata_o
);

  import prefetch_pkg::*;

  // Storage array
  logic [ADDR_W-1:0]  mem_q [FIFO_DEPTH];

  logic [PTR_W-1:0]   wptr_q;
  logic [PTR_W-1:0]   rptr_q;
  logic [CNT_W-1:0]   cnt_q;

  logic               push;
  logic               pop;

  //////////////////////////////////////////////////////////////////////
  // Handshakes
  //////////////////////////////////////////////////////////////////////

  // A flush wins over both push and pop
  assign push = push_i && !flush_i;
  assign pop  = valid_o && ready_i && !flush_i;

  assign valid_o = (cnt_q != '0);
  assign rdata_o = mem_q[rptr_q];
  assign cnt_o   = cnt_q;

  //////////////////////////////////////////////////////////////////////
  // Pointers and count
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wptr_q <= '0;
      rptr_q <= '0;
      cnt_q  <= '0;
    end else if (flush_i) begin
      wptr_q <= '0;
      rptr_q <= '0;
      cnt_q  <= '0;
    end else begin
      // Pointers wrap naturally, depth is a power of two
      if (push) begin
        wptr_q <= wptr_q + PTR_W'(1);
      end
      if (pop) begin
        rptr_q <= rptr_q + PTR_W'(1);
      end
      // Push and pop together leave the count unchanged
      case ({push, pop})
        2'b10:   cnt_q <= cnt_q + CNT_W'(1);
        2'b01:   cnt_q <= cnt_q - CNT_W'(1);
        default: cnt_q <= cnt_q;
      endcase
    end
  end

  // Data write
  always_ff @(posedge clk) begin
    if (push) begin
      mem_q[wptr_q] <= push_data_i;
    end
  end

endmodule

//--- design/obi_instr_if.sv
module obi_instr_if (
  input  logic                             clk,
  input  logic                             rst_n,

  // Transaction request from the controller
  input  logic                             trans_valid_i,
  output logic                             trans_ready_o,
  input  logic [prefetch_pkg::ADDR_W-1:0]  trans_addr_i,

  // Transaction response to controller and FIFO
  output logic                             resp_valid_o,

  // Instruction bus
  output logic                             instr_req_o,
  input  logic                             instr_gnt_i,
  output logic [prefetch_pkg::ADDR_W-1:0]  instr_addr_o,
  input  logic                             instr_rvalid_i
);

  import prefetch_pkg::*;

  ifc_state_e         state_q;
  ifc_state_e         state_d;

  // Address of a request waiting for its grant
  logic [ADDR_W-1:0]  addr_q;
  logic               latch_req;

  //////////////////////////////////////////////////////////////////////
  // Bus request
  //////////////////////////////////////////////////////////////////////

  // Transparent state passes the request through in the same cycle
  // Registered state holds request and address until the grant
  always_comb begin
    if (state_q == IFC_TRANSPARENT) begin
      instr_req_o  = trans_valid_i;
      instr_addr_o = trans_addr_i;
    end else begin
      instr_req_o  = 1'b1;
      instr_addr_o = addr_q;
    end
  end

  // Request seen on the bus without a grant must stay stable
  assign latch_req = (state_q == IFC_TRANSPARENT) && trans_valid_i && !instr_gnt_i;

  // A transparent request is taken over by the adapter right away
  // Nothing new is taken while one is held
  assign trans_ready_o = (state_q == IFC_TRANSPARENT);

  // Responses need no buffering, the FIFO always has room
  assign resp_valid_o = instr_rvalid_i;

  // Next state
  always_comb begin
    state_d = state_q;
    unique case (state_q)
      IFC_TRANSPARENT: begin
        if (latch_req) begin
          state_d = IFC_REGISTERED;
        end
      end
      IFC_REGISTERED: begin
        // Back to pass through once the held request is granted
        if (instr_gnt_i) begin
          state_d = IFC_TRANSPARENT;
        end
      end
      default: begin
        state_d = IFC_TRANSPARENT;
      end
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= IFC_TRANSPARENT;
    end else begin
      state_q <= state_d;
    end
  end

  // Held address
  always_ff @(posedge clk) begin
    if (latch_req) begin
      addr_q <= trans_addr_i;
    end
  end

endmodule

//--- design/prefetch_buffer.sv
module prefetch_buffer (
  input  logic                             clk,
  input  logic                             rst_n,

  // Fetch stage control
  input  logic                             req_i,
  input  logic                             branch_i,
  input  logic [prefetch_pkg::ADDR_W-1:0]  branch_addr_i,

  // Instruction words to the fetch stage
  output logic                             fetch_valid_o,
  input  logic                             fetch_ready_i,
  output logic [prefetch_pkg::ADDR_W-1:0]  fetch_rdata_o,
  output logic                             busy_o,

  // Instruction bus
  output logic                             instr_req_o,
  input  logic                             instr_gnt_i,
  output logic [prefetch_pkg::ADDR_W-1:0]  instr_addr_o,
  input  logic                             instr_rvalid_i,
  input  logic [prefetch_pkg::ADDR_W-1:0]  instr_rdata_i
);

  import prefetch_pkg::*;

  // Controller to bus adapter
  logic               trans_valid;
  logic               trans_ready;
  logic [ADDR_W-1:0]  trans_addr;

  // Response strobe seen by controller and FIFO
  logic               resp_valid;

  // Controller to FIFO
  logic               fifo_push;
  logic [CNT_W-1:0]   fifo_cnt;

  // Request generation and stale response filtering
  prefetch_ctrl u_ctrl (
    .clk           (clk),
    .rst_n         (rst_n),
    .req_i         (req_i),
    .branch_i      (branch_i),
    .branch_addr_i (branch_addr_i),
    .busy_o        (busy_o),
    .trans_valid_o (trans_valid),
    .trans_ready_i (trans_ready),
    .trans_addr_o  (trans_addr),
    .resp_valid_i  (resp_valid),
    .fifo_push_o   (fifo_push),
    .fifo_cnt_i    (fifo_cnt)
  );

  // Bus protocol adapter
  obi_instr_if u_obi_if (
    .clk            (clk),
    .rst_n          (rst_n),
    .trans_valid_i  (trans_valid),
    .trans_ready_o  (trans_ready),
    .trans_addr_i   (trans_addr),
    .resp_valid_o   (resp_valid),
    .instr_req_o    (instr_req_o),
    .instr_gnt_i    (instr_gnt_i),
    .instr_addr_o   (instr_addr_o),
    .instr_rvalid_i (instr_rvalid_i)
  );

  // Word buffer, a branch empties it
  fetch_fifo u_fifo (
    .clk         (clk),
    .rst_n       (rst_n),
    .flush_i     (branch_i),
    .push_i      (fifo_push),
    .push_data_i (instr_rdata_i),
    .cnt_o       (fifo_cnt),
    .valid_o     (fetch_valid_o),
    .ready_i     (fetch_ready_i),
    .rdata_o     (fetch_rdata_o)
  );

endmodule

//--- design/prefetch_ctrl.sv
module prefetch_ctrl (
  input  logic                             clk,
  input  logic                             rst_n,

  // Fetch stage control
  input  logic                             req_i,
  input  logic                             branch_i,
  input  logic [prefetch_pkg::ADDR_W-1:0]  branch_addr_i,
  output logic                             busy_o,

  // Transaction request towards the bus adapter
  output logic                             trans_valid_o,
  input  logic                             trans_ready_i,
  output logic [prefetch_pkg::ADDR_W-1:0]  trans_addr_o,

  // Transaction response from the bus adapter
  input  logic                             resp_valid_i,

  // Fetch FIFO
  output logic                             fifo_push_o,
  input  logic [prefetch_pkg::CNT_W-1:0]   fifo_cnt_i
);

  import prefetch_pkg::*;

  pf_state_e            state_q;
  pf_state_e            state_d;

  // Outstanding transactions
  logic [CNT_W-1:0]     cnt_q;
  logic [CNT_W-1:0]     cnt_d;
  logic                 count_up;
  logic                 count_down;

  // Responses still to be dropped after a branch
  logic [CNT_W-1:0]     flush_cnt_q;
  logic [CNT_W-1:0]     flush_cnt_d;

  // Words in the FIFO plus words on their way
  logic [CNT_W:0]       occupancy;

  logic [ADDR_W-1:0]    trans_addr_q;
  logic [ADDR_W-1:0]    trans_addr_incr;
  logic [ADDR_W-1:0]    aligned_branch_addr;
  logic                 trans_accept;

  //////////////////////////////////////////////////////////////////////
  // Request generation
  //////////////////////////////////////////////////////////////////////

  // Only word fetches, low address bits are dropped
  assign aligned_branch_addr = branch_addr_i & ~(ADDR_W'(WORD_BYTES - 1));

  // Next sequential word
  assign trans_addr_incr = trans_addr_q + ADDR_W'(WORD_BYTES);

  // Every issued request must find a free FIFO slot on its response
  assign occupancy     = {1'b0, fifo_cnt_i} + {1'b0, cnt_q};
  assign trans_valid_o = req_i && (occupancy < (CNT_W + 1)'(FIFO_DEPTH));
  assign trans_accept  = trans_valid_o && trans_ready_i;

  // Busy while anything is in flight or being requested
  assign busy_o = (cnt_q != '0) || trans_valid_o;

  // Address selection and pending branch FSM
  always_comb begin
    state_d      = state_q;
    trans_addr_o = trans_addr_q;
    unique case (state_q)
      PF_IDLE: begin
        trans_addr_o = branch_i ? aligned_branch_addr : trans_addr_incr;
        // Target not taken by the adapter yet, keep it pending
        if (branch_i && !trans_accept) begin
          state_d = PF_BRANCH_WAIT;
        end
      end
      PF_BRANCH_WAIT: begin
        // Replay the stored target, a newer branch overrides it
        trans_addr_o = branch_i ? aligned_branch_addr : trans_addr_q;
        if (trans_accept) begin
          state_d = PF_IDLE;
        end
      end
      default: begin
        state_d = PF_IDLE;
      end
    endcase
  end

  //////////////////////////////////////////////////////////////////////
  // Response handling
  //////////////////////////////////////////////////////////////////////

  // Stale responses are dropped here
  // Words already buffered are dropped by the FIFO flush
  assign fifo_push_o = resp_valid_i && !(branch_i || (flush_cnt_q != '0));

  assign count_up   = trans_accept;
  assign count_down = resp_valid_i;

  // Outstanding transaction counter
  always_comb begin
    case ({count_up, count_down})
      2'b01:   cnt_d = cnt_q - CNT_W'(1);
      2'b10:   cnt_d = cnt_q + CNT_W'(1);
      default: cnt_d = cnt_q;
    endcase
  end

  // Flush counter
  always_comb begin
    flush_cnt_d = flush_cnt_q;
    if (branch_i) begin
      // Everything issued before the branch belongs to the old stream
      flush_cnt_d = cnt_q;
      // A response in the branch cycle is dropped right away
      if (resp_valid_i && (cnt_q != '0)) begin
        flush_cnt_d = cnt_q - CNT_W'(1);
      end
    end else if (resp_valid_i && (flush_cnt_q != '0)) begin
      flush_cnt_d = flush_cnt_q - CNT_W'(1);
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Registers
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q      <= PF_IDLE;
      cnt_q        <= '0;
      flush_cnt_q  <= '0;
      trans_addr_q <= '0;
    end else begin
      state_q     <= state_d;
      cnt_q       <= cnt_d;
      flush_cnt_q <= flush_cnt_d;
      // Keep the branch target even when it is not accepted yet
      if (branch_i || trans_accept) begin
        trans_addr_q <= trans_addr_o;
      end
    end
  end

endmodule

//--- design/prefetch_pkg.sv
package prefetch_pkg;

  // Number of words in the fetch FIFO
  // Also the limit on outstanding plus buffered words
  localparam int unsigned FIFO_DEPTH = 4;

  // Occupancy and transaction counters, 0 to FIFO_DEPTH
  localparam int unsigned CNT_W = 3;

  // FIFO read and write pointers
  localparam int unsigned PTR_W = 2;

  // Instruction address and data width
  localparam int unsigned ADDR_W = 32;

  // Address step between sequential words
  localparam int unsigned WORD_BYTES = 4;

  // Prefetch controller states
  typedef enum logic {PF_IDLE, PF_BRANCH_WAIT} pf_state_e;

  // Bus adapter states
  typedef enum logic {IFC_TRANSPARENT, IFC_REGISTERED} ifc_state_e;

endpackage

//--- prefetch_buffer.f
design/prefetch_pkg.sv
design/prefetch_ctrl.sv
design/fetch_fifo.sv
design/obi_instr_if.sv
design/prefetch_buffer.sv
verif/obi_mem_model.sv
verif/tb_prefetch_buffer.sv

//--- verif/obi_mem_model.sv
module obi_mem_model (
  input  logic                             clk,
  input  logic                             rst_n,

  // Instruction bus, slave side
  input  logic                             instr_req_i,
  output logic                             instr_gnt_o,
  input  logic [prefetch_pkg::ADDR_W-1:0]  instr_addr_i,
  output logic                             instr_rvalid_o,
  output logic [prefetch_pkg::ADDR_W-1:0]  instr_rdata_o,

  // Fetch side, used to track words held in the FIFO
  input  logic                             branch_i,
  input  logic                             fetch_valid_i,
  input  logic                             fetch_ready_i,

  // Protocol observations for the testbench
  output logic                             addr_unstable_o,
  output int unsigned                      occupancy_o
);
  timeunit 1ns;
  timeprecision 1ps;

  import prefetch_pkg::*;

  logic [31:0]        lfsr_q = 32'h9784_27e4;

  // Granted requests waiting for their response, oldest first
  logic [ADDR_W-1:0]  pend_addr [$];
  int unsigned        pend_due [$];

  int unsigned        cyc;
  int unsigned        due;
  int unsigned        next_due;
  int unsigned        gnt_delay;
  int unsigned        stale;
  int unsigned        words;
  logic               held_q;
  logic [ADDR_W-1:0]  held_addr_q;

  // Fibonacci LFSR, taps 32 22 2 1, one step per bit
  function automatic int unsigned lfsr_bits(int unsigned n);
    int unsigned v;
    logic        fb;
    v = 0;
    for (int unsigned i = 0; i < n; i++) begin
      fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
      lfsr_q = {lfsr_q[30:0], fb};
      v      = (v << 1) | fb;
    end
    return v;
  endfunction

  initial begin
    instr_gnt_o    = 1'b0;
    instr_rvalid_o = 1'b0;
    instr_rdata_o  = '0;
  end

  //////////////////////////////////////////////////////////////////////
  // Bus observation at the rising edge
  //////////////////////////////////////////////////////////////////////

  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pend_addr.delete();
      pend_due.delete();
      cyc             = 0;
      due             = 0;
      gnt_delay       = 0;
      stale           = 0;
      words           = 0;
      held_q          = 1'b0;
      held_addr_q     = '0;
      addr_unstable_o = 1'b0;
      occupancy_o     = 0;
    end else begin
      // A request waiting for grant keeps request and address
      if (held_q && !(instr_req_i && (instr_addr_i == held_addr_q))) begin
        addr_unstable_o = 1'b1;
      end
      // Branch empties the FIFO, all older transactions turn stale
      if (branch_i) begin
        stale = pend_addr.size() + int'(held_q) - int'(instr_rvalid_o);
        words = 0;
      end else begin
        if (instr_rvalid_o && (stale != 0)) begin
          stale--;
        end else if (instr_rvalid_o) begin
          words++;
        end
        if (fetch_valid_i && fetch_ready_i) begin
          words--;
        end
      end
      if (instr_rvalid_o) begin
        void'(pend_addr.pop_front());
        void'(pend_due.pop_front());
      end
      held_q      = instr_req_i && !instr_gnt_o;
      held_addr_q = instr_addr_i;
      if (instr_req_i && instr_gnt_o) begin
        // Latency 1 to 3, in order, one response per cycle
        next_due = cyc + 1 + lfsr_bits(2) % 3;
        due      = (next_due > due) ? next_due : due + 1;
        pend_addr.push_back(instr_addr_i);
        pend_due.push_back(due);
        gnt_delay = lfsr_bits(2) % 3;
      end else if (instr_req_i && (gnt_delay != 0)) begin
        gnt_delay--;
      end
      occupancy_o = pend_addr.size() + words;
      cyc++;
    end
  end

  // Grant and response driven on the falling edge
  always @(negedge clk) begin
    instr_gnt_o    = rst_n && (gnt_delay == 0);
    instr_rvalid_o = rst_n && (pend_due.size() != 0) && (pend_due[0] <= cyc);
    instr_rdata_o  = instr_rvalid_o ? (pend_addr[0] ^ 32'hA5A5_0000) : '0;
  end

endmodule

//--- verif/tb_prefetch_buffer.sv
module tb_prefetch_buffer;
  timeunit 1ns;
  timeprecision 1ps;

  import prefetch_pkg::*;

  localparam int unsigned       NUM_ENTRIES  = 6;
  localparam int unsigned       WORD_TIMEOUT = 200;
  localparam int unsigned       BUSY_TIMEOUT = 100;
  localparam logic [ADDR_W-1:0] RDATA_MASK   = 32'hA5A5_0000;

  // Target, first word address, words taken, random ready, drop req_i after
  typedef struct packed {
    logic [ADDR_W-1:0] target;
    logic [ADDR_W-1:0] start;
    logic [7:0]        count;
    logic              stall;
    logic              drop;
  } stim_t;

  stim_t stim [NUM_ENTRIES] = '{
    '{32'h0000_1000, 32'h0000_1000, 8'd6,  1'b0, 1'b0},
    '{32'h0000_2002, 32'h0000_2000, 8'd5,  1'b0, 1'b0},
    '{32'h0000_3000, 32'h0000_3000, 8'd12, 1'b1, 1'b0},
    '{32'h0000_0ffd, 32'h0000_0ffc, 8'd3,  1'b0, 1'b1},
    '{32'h8000_0010, 32'h8000_0010, 8'd9,  1'b1, 1'b0},
    '{32'hffff_fff9, 32'hffff_fff8, 8'd4,  1'b0, 1'b1}
  };

  logic               clk = 1'b0;
  logic               rst_n;
  logic               req;
  logic               branch;
  logic [ADDR_W-1:0]  branch_addr;
  logic               fetch_valid;
  logic               fetch_ready;
  logic [ADDR_W-1:0]  fetch_rdata;
  logic               busy;
  logic               instr_req;
  logic               instr_gnt;
  logic [ADDR_W-1:0]  instr_addr;
  logic               instr_rvalid;
  logic [ADDR_W-1:0]  instr_rdata;
  logic               addr_unstable;
  int unsigned        bus_occupancy;
  logic [31:0]        lfsr_q = 32'h9784_27e4;

  always #4 clk = ~clk;

  prefetch_buffer dut_i (
    .clk(clk), .rst_n(rst_n), .req_i(req), .branch_i(branch), .branch_addr_i(branch_addr),
    .fetch_valid_o(fetch_valid), .fetch_ready_i(fetch_ready), .fetch_rdata_o(fetch_rdata),
    .busy_o(busy), .instr_req_o(instr_req), .instr_gnt_i(instr_gnt),
    .instr_addr_o(instr_addr), .instr_rvalid_i(instr_rvalid), .instr_rdata_i(instr_rdata)
  );

  // Memory model with random grant delay and latency that also watches the bus rules
  obi_mem_model mem_i (
    .clk(clk), .rst_n(rst_n), .instr_req_i(instr_req), .instr_gnt_o(instr_gnt),
    .instr_addr_i(instr_addr), .instr_rvalid_o(instr_rvalid), .instr_rdata_o(instr_rdata),
    .branch_i(branch), .fetch_valid_i(fetch_valid), .fetch_ready_i(fetch_ready),
    .addr_unstable_o(addr_unstable), .occupancy_o(bus_occupancy)
  );

  //////////////////////////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////////////////////////

  // Fibonacci LFSR with taps 32 22 2 1
  function automatic logic lfsr_bit();
    logic fb;
    fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
    lfsr_q = {lfsr_q[30:0], fb};
    return fb;
  endfunction

  // Memory returns the word address scrambled with a fixed mask
  function automatic logic [ADDR_W-1:0] expected_word(logic [ADDR_W-1:0] start, int unsigned k);
    return (start + ADDR_W'(k * WORD_BYTES)) ^ RDATA_MASK;
  endfunction

  task automatic check_equal(logic [31:0] actual, logic [31:0] expected, string msg);
    if (actual !== expected) begin
      $display("error at %0t: %s, got %h, expected %h", $time, msg, actual, expected);
      $display("Result: FAILED");
      $fatal(1, "value mismatch");
    end
  endtask

  task automatic report_timeout(string what);
    $display("Timed out at %0t while waiting for %s", $time, what);
    $display("Result: FAILED");
    $fatal(1, "timeout");
  endtask

  // Bus rules seen by the memory model
  always @(negedge clk) begin
    if (rst_n === 1'b1) begin
      check_equal(32'(addr_unstable), 32'd0, "bus request changed before grant");
      check_equal(32'(bus_occupancy <= FIFO_DEPTH), 32'd1, "outstanding plus buffered too high");
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Stimulus
  //////////////////////////////////////////////////////////////////////

  initial begin
    int unsigned k;
    int unsigned waited;
    rst_n       = 1'b0;
    req         = 1'b0;
    branch      = 1'b0;
    branch_addr = '0;
    fetch_ready = 1'b0;
    repeat (4) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    // Idle after reset
    @(posedge clk);
    check_equal(32'(instr_req), 32'd0, "instr_req_o after reset");
    check_equal(32'(fetch_valid), 32'd0, "fetch_valid_o after reset");
    check_equal(32'(busy), 32'd0, "busy_o after reset");

    for (int unsigned e = 0; e < NUM_ENTRIES; e++) begin
      // One cycle branch pulse with nothing consumed
      @(negedge clk);
      req         = 1'b1;
      branch      = 1'b1;
      branch_addr = stim[e].target;
      fetch_ready = 1'b0;
      @(negedge clk);
      branch = 1'b0;
      // FIFO is empty after the flush so the target is requested or in flight
      @(posedge clk);
      check_equal(32'(busy), 32'd1, "busy_o after branch");
      @(negedge clk);
      // Long stall first so the FIFO fills up
      if (stim[e].stall) begin
        repeat (40) @(negedge clk);
      end
      k      = 0;
      waited = 0;
      while (k < stim[e].count) begin
        fetch_ready = stim[e].stall ? lfsr_bit() : 1'b1;
        @(posedge clk);
        if (fetch_valid && fetch_ready) begin
          check_equal(fetch_rdata, expected_word(stim[e].start, k), "fetched word");
          k++;
          waited = 0;
        end else begin
          waited++;
          if (waited > WORD_TIMEOUT) begin
            report_timeout("an instruction word on fetch_valid_o");
          end
        end
        @(negedge clk);
      end
      fetch_ready = 1'b0;
      // Drop req_i here or let the next branch hit in-flight requests
      if (stim[e].drop) begin
        req    = 1'b0;
        waited = 0;
        @(posedge clk);
        while (busy) begin
          waited++;
          if (waited > BUSY_TIMEOUT) begin
            report_timeout("busy_o to fall after req_i dropped");
          end
          @(posedge clk);
        end
      end
    end

    $display("Result: PASSED");
    $finish;
  end

endmodule
